// File: hw/decode.sv
//##########################################################################
// Decode stage: opcode decoder, immediate extension, illegal opcode check
//##########################################################################
`timescale 1ns/1ps

module decode (
   input  procIsaPkg::instr_t  instr,
   output procCtrlPkg::ctrl_t  ctrl,
   output procIsaPkg::regIdx_t rsIdx,
   output procIsaPkg::regIdx_t rtIdx,
   output procIsaPkg::word_t   imm5Ext,
   output procIsaPkg::word_t   imm8Ext,
   output procIsaPkg::word_t   disp11Ext
);
   import procIsaPkg::*;
   import procCtrlPkg::*;

   opcode_t opcode;

   assign opcode = opcode_t'(instr[OpMsb:OpLsb]);
   assign rsIdx  = instr[RsMsb:RsLsb];
   assign rtIdx  = instr[RtMsb:RtLsb];   // Also the store data register

   assign imm5Ext   = {{(WordW-Imm5Msb-1){instr[Imm5Msb]}}, instr[Imm5Msb:0]};
   assign imm8Ext   = {{(WordW-Imm8Msb-1){instr[Imm8Msb]}}, instr[Imm8Msb:0]};
   assign disp11Ext = {{(WordW-Disp11Msb-1){instr[Disp11Msb]}}, instr[Disp11Msb:0]};

   always_comb begin
      // Defaults give a nop
      ctrl.aluFunc  = AluAdd;
      ctrl.aluSrcB  = SrcBReg;
      ctrl.wbSrc    = WbAlu;
      ctrl.pcSrc    = PcSeq;
      ctrl.regWrite = 1'b0;
      ctrl.regDst   = instr[RdMsb:RdLsb];
      ctrl.memWrite = 1'b0;
      ctrl.cmpLess  = 1'b0;
      ctrl.halt     = 1'b0;
      ctrl.illegal  = 1'b0;

      case (opcode)
         OpNop: ;
         OpHalt: ctrl.halt = 1'b1;
         OpRtype: begin
            ctrl.aluFunc  = aluFunc_t'(instr[FuncMsb:FuncLsb]);
            ctrl.regWrite = 1'b1;
         end
         OpAddi: begin
            ctrl.aluSrcB  = SrcBImm5;
            ctrl.regDst   = instr[IrdMsb:IrdLsb];
            ctrl.regWrite = 1'b1;
         end
         OpLbi: begin
            ctrl.wbSrc    = WbImm;
            ctrl.regDst   = instr[RsMsb:RsLsb];   // lbi targets rs
            ctrl.regWrite = 1'b1;
         end
         OpLd: begin
            ctrl.aluSrcB  = SrcBImm5;   // Address is rs + imm5
            ctrl.wbSrc    = WbMem;
            ctrl.regDst   = instr[IrdMsb:IrdLsb];
            ctrl.regWrite = 1'b1;
         end
         OpSt: begin
            ctrl.aluSrcB  = SrcBImm5;
            ctrl.memWrite = 1'b1;
         end
         OpSeq, OpSlt: begin
            ctrl.wbSrc    = WbCmp;
            ctrl.cmpLess  = (opcode == OpSlt);
            ctrl.regWrite = 1'b1;
         end
         OpBeqz: ctrl.pcSrc = PcBeqz;
         OpBnez: ctrl.pcSrc = PcBnez;
         OpJ:    ctrl.pcSrc = PcJump;
         OpJal: begin
            ctrl.pcSrc    = PcJump;
            ctrl.wbSrc    = WbPcPlusOne;
            ctrl.regDst   = LinkReg;
            ctrl.regWrite = 1'b1;
         end
         default: ctrl.illegal = 1'b1;   // Writes stay off
      endcase
   end

endmodule

// File: hw/execution.sv
//##########################################################################
// Execution stage with ALU, signed/equal compare and next-PC selection
//##########################################################################
`timescale 1ns/1ps

module execution (
   input  procCtrlPkg::ctrl_t ctrl,
   input  procIsaPkg::word_t  pcPlusOne,
   input  procIsaPkg::word_t  rsData,
   input  procIsaPkg::word_t  rtData,
   input  procIsaPkg::word_t  imm5Ext,
   input  procIsaPkg::word_t  disp11Ext,
   input  procIsaPkg::word_t  imm8Ext,
   output procIsaPkg::word_t  aluOut,
   output logic               cmpFlag,
   output procIsaPkg::word_t  nextPc
);
   import procIsaPkg::*;
   import procCtrlPkg::*;

   word_t opB;
   word_t branchTgt;
   word_t jumpTgt;
   logic  eqFlag;
   logic  ltFlag;
   logic  rsZero;

   assign opB = (ctrl.aluSrcB == SrcBImm5) ? imm5Ext : rtData;

   always_comb begin
      case (ctrl.aluFunc)
         AluAdd:  aluOut = rsData + opB;
         AluSub:  aluOut = rsData - opB;   // rs minus rt
         AluAnd:  aluOut = rsData & opB;
         AluXor:  aluOut = rsData ^ opB;
         default: aluOut = rsData + opB;
      endcase
   end

   assign eqFlag  = (rsData == rtData);
   assign ltFlag  = ($signed(rsData) < $signed(rtData));
   assign cmpFlag = ctrl.cmpLess ? ltFlag : eqFlag;

   // Targets are relative to the following word
   assign branchTgt = pcPlusOne + imm8Ext;
   assign jumpTgt   = pcPlusOne + disp11Ext;
   assign rsZero    = (rsData == '0);

   always_comb begin
      case (ctrl.pcSrc)
         PcSeq:   nextPc = pcPlusOne;
         PcBeqz:  nextPc = rsZero ? branchTgt : pcPlusOne;
         PcBnez:  nextPc = rsZero ? pcPlusOne : branchTgt;
         PcJump:  nextPc = jumpTgt;
         default: nextPc = pcPlusOne;
      endcase
   end

endmodule

// File: hw/fetch.sv
//##########################################################################
// Fetch stage with PC register, run/halt FSM and loadable instruction RAM
//##########################################################################
`timescale 1ns/1ps

module fetch #(
   parameter int ImemDepth = 256
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  imemWe,
   input  procIsaPkg::imemAddr_t imemAddr,
   input  procIsaPkg::instr_t    imemData,
   input  procIsaPkg::word_t     nextPc,
   input  logic                  haltReq,
   output procIsaPkg::instr_t    instr,
   output procIsaPkg::word_t     pc,
   output procIsaPkg::word_t     pcPlusOne,
   output logic                  halted
);
   import procIsaPkg::*;

   typedef enum logic {
      StRun,
      StHalted
   } state_t;

   state_t state;
   instr_t imem [ImemDepth];

   // Program load only while the core sits in reset
   always_ff @(posedge clk) begin
      if (imemWe && !rstN) begin
         imem[imemAddr] <= imemData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= StRun;
         pc    <= '0;
      end else if (state == StRun) begin
         if (haltReq) begin
            state <= StHalted;   // PC stays on the halting word
         end else begin
            pc <= nextPc;
         end
      end
   end

   assign instr     = imem[imemAddr_t'(pc)];   // Combinational read
   assign pcPlusOne = pc + word_t'(1);
   assign halted    = (state == StHalted);

   imemLoadInReset: assert property (@(posedge clk) imemWe |-> !rstN)
      else $error("instruction memory written while out of reset");

endmodule

// File: hw/memWriteback.sv
//##########################################################################
// Data memory with debug read port and register write-data selection
//##########################################################################
`timescale 1ns/1ps

module memWriteback #(
   parameter int DmemDepth = 256
) (
   input  logic                  clk,
   input  procCtrlPkg::ctrl_t    ctrl,
   input  procIsaPkg::word_t     aluOut,
   input  procIsaPkg::word_t     rtData,
   input  procIsaPkg::word_t     imm8Ext,
   input  procIsaPkg::word_t     pcPlusOne,
   input  logic                  cmpFlag,
   input  logic                  running,
   input  procIsaPkg::dmemAddr_t dbgAddr,
   output procIsaPkg::word_t     dbgData,
   output procIsaPkg::word_t     wrData
);
   import procIsaPkg::*;
   import procCtrlPkg::*;

   word_t     dmem [DmemDepth];
   dmemAddr_t addr;
   word_t     rdData;

   assign addr = dmemAddr_t'(aluOut);   // Upper address bits ignored

   always_ff @(posedge clk) begin
      if (ctrl.memWrite && running) begin
         dmem[addr] <= rtData;
      end
   end

   assign rdData  = dmem[addr];
   assign dbgData = dmem[dbgAddr];   // Usable at any time

   always_comb begin
      case (ctrl.wbSrc)
         WbAlu:       wrData = aluOut;
         WbMem:       wrData = rdData;
         WbImm:       wrData = imm8Ext;
         WbPcPlusOne: wrData = pcPlusOne;
         WbCmp:       wrData = {{(WordW-1){1'b0}}, cmpFlag};
         default:     wrData = aluOut;
      endcase
   end

endmodule

// File: hw/proc.sv
//##########################################################################
// Processor top level linking the five stages
// Holds the sticky error flag and gates register writes on run state
//##########################################################################
`timescale 1ns/1ps

module proc #(
   parameter int ImemDepth = 256,
   parameter int DmemDepth = 256
) (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  imemWe,
   input  procIsaPkg::imemAddr_t imemAddr,
   input  procIsaPkg::instr_t    imemData,
   input  procIsaPkg::dmemAddr_t dbgAddr,
   output procIsaPkg::word_t     dbgData,
   output logic                  halted,
   output logic                  err
);
   import procIsaPkg::*;
   import procCtrlPkg::*;

   instr_t  instr;
   word_t   pc, pcPlusOne, nextPc;
   ctrl_t   ctrl;
   regIdx_t rsIdx, rtIdx;
   word_t   imm5Ext, imm8Ext, disp11Ext;
   word_t   rsData, rtData, aluOut, wrData;
   logic    cmpFlag;
   logic    running;
   logic    regWe;

   assign running = rstN && !halted;   // No stray writes while loading
   assign regWe   = ctrl.regWrite && running;

   fetch #(.ImemDepth(ImemDepth)) fetch0 (
      .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
      .imemData(imemData), .nextPc(nextPc), .haltReq(ctrl.halt || ctrl.illegal),
      .instr(instr), .pc(pc), .pcPlusOne(pcPlusOne), .halted(halted)
   );

   decode decode0 (
      .instr(instr), .ctrl(ctrl), .rsIdx(rsIdx), .rtIdx(rtIdx),
      .imm5Ext(imm5Ext), .imm8Ext(imm8Ext), .disp11Ext(disp11Ext)
   );

   regFile regFile0 (
      .clk(clk), .rstN(rstN), .rsIdx(rsIdx), .rtIdx(rtIdx), .wrEn(regWe),
      .wrIdx(ctrl.regDst), .wrData(wrData), .rsData(rsData), .rtData(rtData)
   );

   execution exec0 (
      .ctrl(ctrl), .pcPlusOne(pcPlusOne), .rsData(rsData), .rtData(rtData),
      .imm5Ext(imm5Ext), .disp11Ext(disp11Ext), .imm8Ext(imm8Ext),
      .aluOut(aluOut), .cmpFlag(cmpFlag), .nextPc(nextPc)
   );

   memWriteback #(.DmemDepth(DmemDepth)) memWb0 (
      .clk(clk), .ctrl(ctrl), .aluOut(aluOut), .rtData(rtData),
      .imm8Ext(imm8Ext), .pcPlusOne(pcPlusOne), .cmpFlag(cmpFlag),
      .running(running), .dbgAddr(dbgAddr), .dbgData(dbgData), .wrData(wrData)
   );

   always_ff @(posedge clk) begin
      if (!rstN) begin
         err <= 1'b0;
      end else if (ctrl.illegal && running) begin
         err <= 1'b1;   // Held until the next reset
      end
   end

   opcodeKnown: assert property (@(posedge clk) disable iff (!rstN)
      !$isunknown(instr[OpMsb:OpLsb]))
      else $error("unknown opcode fetched at pc %0d", pc);

endmodule

// File: hw/procCtrlPkg.sv
//##########################################################################
// Control definitions for the single-cycle processor
// Source selects and the per-instruction control word built by decode
//##########################################################################
package procCtrlPkg;

   typedef enum logic {
      SrcBReg,
      SrcBImm5
   } aluSrcB_t;

   typedef enum logic [2:0] {
      WbAlu,
      WbMem,
      WbImm,
      WbPcPlusOne,
      WbCmp
   } wbSrc_t;

   typedef enum logic [1:0] {
      PcSeq,
      PcBeqz,
      PcBnez,
      PcJump
   } pcSrc_t;

   typedef struct packed {
      procIsaPkg::aluFunc_t aluFunc;
      aluSrcB_t             aluSrcB;
      wbSrc_t               wbSrc;
      pcSrc_t               pcSrc;
      logic                 regWrite;
      procIsaPkg::regIdx_t  regDst;
      logic                 memWrite;
      logic                 cmpLess;    // 1 for slt, 0 for seq
      logic                 halt;
      logic                 illegal;
   } ctrl_t;

endpackage

// File: hw/procIsaPkg.sv
//##########################################################################
// Instruction-set definitions for the 16-bit single-cycle processor
// Word and index types, opcode and ALU function encodings, field positions
//##########################################################################
package procIsaPkg;

   localparam int WordW   = 16;
   localparam int RegIdxW = 3;
   localparam int AddrW   = 8;   // Word addresses for both memories
   localparam int OpW     = 5;
   localparam int FuncW   = 2;

   typedef logic [WordW-1:0]   word_t;
   typedef logic [WordW-1:0]   instr_t;
   typedef logic [RegIdxW-1:0] regIdx_t;
   typedef logic [AddrW-1:0]   imemAddr_t;
   typedef logic [AddrW-1:0]   dmemAddr_t;

   typedef enum logic [OpW-1:0] {
      OpNop   = 5'b00000,
      OpHalt  = 5'b00001,
      OpJ     = 5'b00100,
      OpJal   = 5'b00110,
      OpAddi  = 5'b01000,
      OpBeqz  = 5'b01100,
      OpBnez  = 5'b01101,
      OpSt    = 5'b10000,
      OpLd    = 5'b10001,
      OpLbi   = 5'b11000,
      OpRtype = 5'b11011,   // Function code picks the ALU op
      OpSeq   = 5'b11100,
      OpSlt   = 5'b11101
   } opcode_t;

   typedef enum logic [FuncW-1:0] {
      AluAdd = 2'b00,
      AluSub = 2'b01,
      AluAnd = 2'b10,
      AluXor = 2'b11
   } aluFunc_t;

   // Field positions
   localparam int OpMsb     = 15;
   localparam int OpLsb     = 11;
   localparam int RsMsb     = 10;
   localparam int RsLsb     = 8;
   localparam int RtMsb     = 7;
   localparam int RtLsb     = 5;
   localparam int RdMsb     = 4;   // R-form destination
   localparam int RdLsb     = 2;
   localparam int FuncMsb   = 1;
   localparam int FuncLsb   = 0;
   localparam int IrdMsb    = 7;   // I-form destination
   localparam int IrdLsb    = 5;
   localparam int Imm5Msb   = 4;
   localparam int Imm8Msb   = 7;
   localparam int Disp11Msb = 10;

   localparam regIdx_t LinkReg = 3'd7;   // Written by jal

endpackage

// File: hw/regFile.sv
//##########################################################################
// Register file, eight 16-bit registers, two async reads and one write
//##########################################################################
`timescale 1ns/1ps

module regFile (
   input  logic                clk,
   input  logic                rstN,
   input  procIsaPkg::regIdx_t rsIdx,
   input  procIsaPkg::regIdx_t rtIdx,
   input  logic                wrEn,
   input  procIsaPkg::regIdx_t wrIdx,
   input  procIsaPkg::word_t   wrData,
   output procIsaPkg::word_t   rsData,
   output procIsaPkg::word_t   rtData
);
   import procIsaPkg::*;

   localparam int NumRegs = 2 ** RegIdxW;

   word_t regs [NumRegs];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrIdx] <= wrData;
      end
   end

   // No bypass, the write lands at the end of the cycle
   assign rsData = regs[rsIdx];
   assign rtData = regs[rtIdx];

endmodule

// File: run.sh
#!/bin/sh
# Build the processor testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -f vlog.f --top-module procTb -o procTbSim \
   && ./obj_dir/procTbSim | tee /dev/stderr | grep -q "TEST PASSED" \
   && echo "Simulation run succeeded" \
   || { echo "Simulation run did not succeed"; exit 1; }

// File: sim/procTb.sv
//##########################################################################
// Testbench for the 16-bit single-cycle processor
// Loads directed programs in reset, runs them to halt, checks data memory
//##########################################################################
`timescale 1ns/1ps

module procTb;
   import procIsaPkg::*;

   localparam int ResetCycles = 16;
   localparam int RunLimit    = 100;   // Cycles allowed per program
   localparam int LoadCycles  = 64;    // Load, reset and memory checks
   localparam int NumRuns     = 7;
   localparam int WatchdogNs  = NumRuns * (RunLimit + LoadCycles) * 10;
   localparam instr_t HaltWord    = {OpHalt, 11'd0};
   localparam instr_t IllegalWord = 16'h1000;   // Opcode 00010 is unassigned

   logic      clk = 1'b0;
   logic      rstN;
   logic      imemWe;
   imemAddr_t imemAddr;
   instr_t    imemData;
   dmemAddr_t dbgAddr;
   word_t     dbgData;
   logic      halted;
   logic      err;
   instr_t    prog [$];

   proc u_dut (
      .clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
      .imemData(imemData), .dbgAddr(dbgAddr), .dbgData(dbgData),
      .halted(halted), .err(err)
   );

   always #5 clk = ~clk;

   // Register form {op, rs, rt, rd, func}, seq and slt use func 0
   function automatic instr_t rForm(opcode_t op, regIdx_t rd, regIdx_t rs, regIdx_t rt,
                                    logic [1:0] func);
      return {op, rs, rt, rd, func};
   endfunction

   function automatic instr_t iForm(opcode_t op, regIdx_t rd, regIdx_t rs, logic [4:0] imm5);
      return {op, rs, rd, imm5};   // rd is the data register for st
   endfunction

   function automatic instr_t r8Form(opcode_t op, regIdx_t r, logic [7:0] imm8);
      return {op, r, imm8};
   endfunction

   function automatic instr_t jForm(opcode_t op, logic [10:0] disp11);
      return {op, disp11};
   endfunction

   task automatic checkEq(string name, word_t exp, word_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic loadProgram();
      @(posedge clk);
      #1;
      rstN = 1'b0;
      foreach (prog[i]) begin
         imemWe   = 1'b1;
         imemAddr = imemAddr_t'(i);
         imemData = prog[i];
         @(posedge clk);
         #1;
      end
      imemWe = 1'b0;
      repeat (ResetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
   endtask

   task automatic runProgram(string name, logic expErr);
      int cycles;
      cycles = 0;
      loadProgram();
      while (!halted && cycles < RunLimit) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("Error: program %s did not halt within %0d cycles", name, RunLimit);
         $display("TEST FAILED");
         $fatal(1, "processor did not halt");
      end
      checkEq({name, " err"}, word_t'(expErr), word_t'(err));
   endtask

   task automatic checkMem(string name, dmemAddr_t addr, word_t exp);
      @(posedge clk);
      #1;
      dbgAddr = addr;
      @(negedge clk);
      checkEq($sformatf("%s mem[%0d]", name, addr), exp, dbgData);
   endtask

   task automatic testArith();
      word_t a;
      word_t b;
      a = 16'd100;
      b = 16'hfff9;   // -7 sign extended
      prog = '{
         r8Form(OpLbi, 3'd1, 8'd100), r8Form(OpLbi, 3'd2, 8'hf9),
         rForm(OpRtype, 3'd3, 3'd1, 3'd2, AluAdd), rForm(OpRtype, 3'd4, 3'd1, 3'd2, AluSub),
         rForm(OpRtype, 3'd5, 3'd1, 3'd2, AluAnd), rForm(OpRtype, 3'd6, 3'd1, 3'd2, AluXor),
         iForm(OpAddi, 3'd7, 3'd1, 5'h1d),   // Minus 3
         iForm(OpSt, 3'd3, 3'd0, 5'd0), iForm(OpSt, 3'd4, 3'd0, 5'd1),
         iForm(OpSt, 3'd5, 3'd0, 5'd2), iForm(OpSt, 3'd6, 3'd0, 5'd3),
         iForm(OpSt, 3'd7, 3'd0, 5'd4), HaltWord
      };
      runProgram("arith", 1'b0);
      checkMem("arith add", 8'd0, a + b);
      checkMem("arith sub", 8'd1, a - b);
      checkMem("arith and", 8'd2, a & b);
      checkMem("arith xor", 8'd3, a ^ b);
      checkMem("arith addi", 8'd4, a + 16'hfffd);
   endtask

   task automatic testLoadStore();
      prog = '{
         r8Form(OpLbi, 3'd1, 8'h5a), r8Form(OpLbi, 3'd2, 8'h80),
         iForm(OpSt, 3'd1, 3'd0, 5'd6), iForm(OpSt, 3'd2, 3'd0, 5'd7),
         iForm(OpLd, 3'd3, 3'd0, 5'd6), iForm(OpLd, 3'd4, 3'd0, 5'd7),
         rForm(OpRtype, 3'd5, 3'd3, 3'd4, AluAdd), iForm(OpSt, 3'd5, 3'd0, 5'd8),
         HaltWord
      };
      runProgram("ldst", 1'b0);
      checkMem("ldst", 8'd6, 16'h005a);
      checkMem("ldst", 8'd7, 16'hff80);
      checkMem("ldst sum", 8'd8, 16'h005a + 16'hff80);   // Both loads added
   endtask

   task automatic testBranchLoop();
      word_t sum;
      sum = '0;
      for (int k = 1; k <= 10; k++) begin
         sum += word_t'(k);
      end
      prog = '{
         iForm(OpSt, 3'd0, 3'd0, 5'd9),   // Clear the result word
         r8Form(OpLbi, 3'd1, 8'd10), r8Form(OpLbi, 3'd2, 8'd0),
         rForm(OpRtype, 3'd2, 3'd2, 3'd1, AluAdd),   // Loop body, word 3
         iForm(OpAddi, 3'd1, 3'd1, 5'h1f),
         r8Form(OpBnez, 3'd1, 8'hfd),   // Back to word 3
         r8Form(OpBeqz, 3'd2, 8'd1),    // Falls through, sum nonzero
         iForm(OpSt, 3'd2, 3'd0, 5'd9), HaltWord
      };
      runProgram("loop", 1'b0);
      checkMem("loop sum", 8'd9, sum);
   endtask

   task automatic testJumps();
      prog = '{
         iForm(OpSt, 3'd0, 3'd0, 5'd11),
         jForm(OpJal, 11'd1),   // Word 1, hops over the halt
         HaltWord,
         iForm(OpSt, 3'd7, 3'd0, 5'd10),
         jForm(OpJ, 11'd1),
         iForm(OpSt, 3'd7, 3'd0, 5'd11),   // Skipped
         HaltWord
      };
      runProgram("jump", 1'b0);
      checkMem("jump link", 8'd10, 16'd2);   // pcPlusOne of word 1
      checkMem("jump skip", 8'd11, 16'd0);
   endtask

   task automatic testCompares();
      prog = '{
         r8Form(OpLbi, 3'd1, 8'hfb), r8Form(OpLbi, 3'd2, 8'hfe), r8Form(OpLbi, 3'd3, 8'd3),
         rForm(OpSlt, 3'd4, 3'd1, 3'd2, 2'd0), iForm(OpSt, 3'd4, 3'd0, 5'd12),
         rForm(OpSlt, 3'd4, 3'd2, 3'd1, 2'd0), iForm(OpSt, 3'd4, 3'd0, 5'd13),
         rForm(OpSlt, 3'd4, 3'd1, 3'd3, 2'd0), iForm(OpSt, 3'd4, 3'd0, 5'd14),
         rForm(OpSeq, 3'd4, 3'd2, 3'd2, 2'd0), iForm(OpSt, 3'd4, 3'd0, 5'h10),
         rForm(OpSeq, 3'd4, 3'd1, 3'd2, 2'd0), iForm(OpSt, 3'd4, 3'd0, 5'h11),
         HaltWord
      };
      runProgram("cmp", 1'b0);
      checkMem("cmp slt", 8'd12, word_t'(-16'sd5 < -16'sd2));
      checkMem("cmp slt", 8'd13, word_t'(-16'sd2 < -16'sd5));
      checkMem("cmp slt", 8'd14, word_t'(-16'sd5 < 16'sd3));
      checkMem("cmp seq", 8'hf0, word_t'(-16'sd2 == -16'sd2));   // Negative imm5 wraps
      checkMem("cmp seq", 8'hf1, word_t'(-16'sd5 == -16'sd2));
   endtask

   task automatic testIllegal();
      prog = '{
         r8Form(OpLbi, 3'd1, 8'd1), iForm(OpSt, 3'd0, 3'd0, 5'd15),
         IllegalWord,
         iForm(OpSt, 3'd1, 3'd0, 5'd15),   // Never reached
         HaltWord
      };
      runProgram("illegal", 1'b1);
      checkMem("illegal", 8'd15, 16'd0);
      prog = '{HaltWord};
      runProgram("after reset", 1'b0);   // Sticky err gone
   endtask

   initial begin
      rstN     = 1'b0;
      imemWe   = 1'b0;
      imemAddr = '0;
      imemData = '0;
      dbgAddr  = '0;
      testArith();
      testLoadStore();
      testBranchLoop();
      testJumps();
      testCompares();
      testIllegal();
      $display("TEST PASSED");
      $finish;
   end

   initial begin
      #(WatchdogNs);
      $display("Error: watchdog expired before the tests finished");
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
   end

endmodule

// File: vlog.f
hw/procIsaPkg.sv
hw/procCtrlPkg.sv
hw/fetch.sv
hw/decode.sv
hw/regFile.sv
hw/execution.sv
hw/memWriteback.sv
hw/proc.sv
sim/procTb.sv
